/* design/pool_pkg.sv */
package pool_pkg;

    localparam int frame_width  = 8;                  // pixels per row and rows per frame
    localparam int frame_last   = frame_width - 1;    // index of the last row and column
    localparam int pool_width   = frame_width / 2;    // pooled outputs per row
    localparam int adrs_width   = 4;
    localparam int buffer_depth = 1 << adrs_width;
    localparam int pair_slot    = buffer_depth - 1;   // holds the even-column pixel of a pair
    localparam int pixel_width  = 16;
    localparam int count_width  = 5;

    // signed result coming out of the systolic array
    typedef logic signed [pixel_width-1:0] pixel_t;

    typedef logic [adrs_width-1:0] adrs_t;

    typedef logic [count_width-1:0] count_t;

    // even rows are buffered, odd rows produce pooled results
    typedef enum logic [1:0]
    {
        idle      = 2'b00,
        buffering = 2'b01,
        working   = 2'b10
    } pool_state_t;

endpackage

/* design/pool_control.sv */
`timescale 1ns/1ps

module pool_control
(
    input  logic            clk,
    input  logic            nrst,
    input  logic            start,
    output pool_pkg::adrs_t adrs1,
    output pool_pkg::adrs_t adrs2,
    output pool_pkg::adrs_t adrs_out,
    output logic            wr_ctrl1,
    output logic            wr_ctrl2,
    output logic            mux_en,
    output logic            pool_done,
    output logic            pooling_finish
);

    pool_pkg::pool_state_t state;
    pool_pkg::pool_state_t next_state;
    pool_pkg::count_t      col_cnt;
    pool_pkg::count_t      next_col_cnt;
    pool_pkg::count_t      row_cnt;
    pool_pkg::count_t      next_row_cnt;
    pool_pkg::adrs_t       half_col;

    logic accept;
    logic even_row;
    logic odd_row;
    logic last_col;
    logic last_row;

    // the pixel sampled with an accepted start is already pixel (0,0)
    assign accept   = (state == pool_pkg::idle) && start;
    assign even_row = accept || (state == pool_pkg::buffering);
    assign odd_row  = (state == pool_pkg::working);

    assign last_col = (col_cnt == pool_pkg::count_t'(pool_pkg::frame_last));
    assign last_row = (row_cnt == pool_pkg::count_t'(pool_pkg::frame_last));

    // one buffer entry per column pair
    assign half_col = pool_pkg::adrs_t'(col_cnt >> 1);

    assign adrs1    = pool_pkg::adrs_t'(pool_pkg::pair_slot);   // even pixel always lands here
    assign adrs2    = half_col;                                 // pair maximum of an even row
    assign adrs_out = half_col;                                 // stored pair maximum for odd rows

    // even columns park the pixel, odd columns consume it
    assign wr_ctrl1 = (even_row || odd_row) && !col_cnt[0];
    assign wr_ctrl2 = even_row && col_cnt[0];
    assign mux_en   = odd_row && col_cnt[0];

    always_comb
    begin
        next_state   = state;
        next_col_cnt = col_cnt;
        next_row_cnt = row_cnt;
        unique case (state)
            pool_pkg::idle:
            begin
                if (start)
                begin
                    next_state   = pool_pkg::buffering;
                    next_col_cnt = pool_pkg::count_t'(1);   // column 0 is taken with start
                    next_row_cnt = '0;
                end
            end
            pool_pkg::buffering:
            begin
                if (last_col)
                begin
                    next_state   = pool_pkg::working;
                    next_col_cnt = '0;
                    next_row_cnt = row_cnt + 1'b1;
                end
                else
                begin
                    next_col_cnt = col_cnt + 1'b1;
                end
            end
            pool_pkg::working:
            begin
                if (last_col)
                begin
                    next_col_cnt = '0;
                    if (last_row)
                    begin
                        // frame ends here, the last result is still in flight
                        next_state   = pool_pkg::idle;
                        next_row_cnt = '0;
                    end
                    else
                    begin
                        next_state   = pool_pkg::buffering;
                        next_row_cnt = row_cnt + 1'b1;
                    end
                end
                else
                begin
                    next_col_cnt = col_cnt + 1'b1;
                end
            end
            default:
            begin
                next_state   = pool_pkg::idle;
                next_col_cnt = '0;
                next_row_cnt = '0;
            end
        endcase
    end

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            state          <= pool_pkg::idle;
            col_cnt        <= '0;
            row_cnt        <= '0;
            pool_done      <= 1'b0;
            pooling_finish <= 1'b0;
        end
        else
        begin
            state          <= next_state;
            col_cnt        <= next_col_cnt;
            row_cnt        <= next_row_cnt;
            pool_done      <= mux_en;                          // lines up with the output register
            pooling_finish <= mux_en && last_row && last_col;  // last block of the frame
        end
    end

    // working rows are the odd rows, so the row parity must follow the state
    no_buffer_write_in_working: assert property (
        @(posedge clk) disable iff (!nrst)
        wr_ctrl2 |-> !row_cnt[0]
    ) else $error("wr_ctrl2 asserted on an odd row");

    mux_only_in_working: assert property (
        @(posedge clk) disable iff (!nrst)
        mux_en |-> row_cnt[0]
    ) else $error("mux_en asserted on an even row");

    finish_with_result: assert property (
        @(posedge clk) disable iff (!nrst)
        pooling_finish |-> pool_done && (state == pool_pkg::idle)
    ) else $error("pooling_finish without pool_done or before the frame ended");

endmodule

/* design/pool_line_buffer.sv */
`timescale 1ns/1ps

module pool_line_buffer
(
    input  logic             clk,
    input  logic             nrst,
    input  logic             wr_ctrl1,
    input  logic             wr_ctrl2,
    input  pool_pkg::adrs_t  adrs1,
    input  pool_pkg::adrs_t  adrs2,
    input  pool_pkg::adrs_t  adrs_out,
    input  pool_pkg::pixel_t wr_data1,
    input  pool_pkg::pixel_t wr_data2,
    output pool_pkg::pixel_t rd_data_out,
    output pool_pkg::pixel_t pair_slot_data
);

    // entries below pool_width hold pair maxima, the last one is the pair slot
    pool_pkg::pixel_t mem [pool_pkg::buffer_depth];

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            for (int i = 0; i < pool_pkg::buffer_depth; i++)
            begin
                mem[i] <= '0;
            end
        end
        else
        begin
            if (wr_ctrl1)
            begin
                mem[adrs1] <= wr_data1;    // even-column pixel
            end
            if (wr_ctrl2)
            begin
                mem[adrs2] <= wr_data2;    // pair maximum of an even row
            end
        end
    end

    // both reads are combinational so the datapath sees them in the same cycle
    assign rd_data_out    = mem[adrs_out];
    assign pair_slot_data = mem[pool_pkg::pair_slot];

    no_write_collision: assert property (
        @(posedge clk) disable iff (!nrst)
        (wr_ctrl1 && wr_ctrl2) |-> (adrs1 != adrs2)
    ) else $error("both write ports target address %0d", adrs1);

    // pair maxima must never overwrite the pair slot
    pair_max_in_range: assert property (
        @(posedge clk) disable iff (!nrst)
        wr_ctrl2 |-> (adrs2 < pool_pkg::pool_width)
    ) else $error("pair maximum written outside the row area at %0d", adrs2);

endmodule

/* design/pool_max_datapath.sv */
`timescale 1ns/1ps

module pool_max_datapath
(
    input  logic             clk,
    input  logic             nrst,
    input  pool_pkg::pixel_t pixel_in,
    input  pool_pkg::pixel_t buffer_data,
    input  pool_pkg::pixel_t pair_slot_data,
    input  logic             mux_en,
    output pool_pkg::pixel_t pair_max,
    output pool_pkg::pixel_t pool_out
);

    pool_pkg::pixel_t block_max;

    // both operands are signed, so the compare is signed
    function automatic pool_pkg::pixel_t signed_max
    (
        input pool_pkg::pixel_t a,
        input pool_pkg::pixel_t b
    );
        return (a > b) ? a : b;
    endfunction

    // held even pixel against the current odd pixel
    assign pair_max = signed_max(pair_slot_data, pixel_in);

    // on odd rows the stored pair maximum closes the 2x2 block
    assign block_max = signed_max(pair_max, buffer_data);

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            pool_out <= '0;
        end
        else if (mux_en)
        begin
            pool_out <= block_max;    // held until the next block completes
        end
    end

    pixel_known_on_load: assert property (
        @(posedge clk) disable iff (!nrst)
        mux_en |-> !$isunknown(pixel_in)
    ) else $error("pixel_in unknown while a pooled result is loaded");

endmodule

/* design/pool_top.sv */
`timescale 1ns/1ps

module pool_top
(
    input  logic             clk,
    input  logic             nrst,
    input  logic             start,
    input  pool_pkg::pixel_t pixel_in,
    output pool_pkg::pixel_t pool_out,
    output logic             pool_valid,
    output logic             pooling_finish
);

    pool_pkg::adrs_t  adrs1;
    pool_pkg::adrs_t  adrs2;
    pool_pkg::adrs_t  adrs_out;
    pool_pkg::pixel_t pair_max;
    pool_pkg::pixel_t rd_data_out;
    pool_pkg::pixel_t pair_slot_data;

    logic wr_ctrl1;
    logic wr_ctrl2;
    logic mux_en;

    pool_control u_control
    (
        .clk            (clk),
        .nrst           (nrst),
        .start          (start),
        .adrs1          (adrs1),
        .adrs2          (adrs2),
        .adrs_out       (adrs_out),
        .wr_ctrl1       (wr_ctrl1),
        .wr_ctrl2       (wr_ctrl2),
        .mux_en         (mux_en),
        .pool_done      (pool_valid),        // registered load strobe is the output valid
        .pooling_finish (pooling_finish)
    );

    // the raw pixel goes to the pair slot, the pair maximum to its column entry
    pool_line_buffer u_line_buffer
    (
        .clk            (clk),
        .nrst           (nrst),
        .wr_ctrl1       (wr_ctrl1),
        .wr_ctrl2       (wr_ctrl2),
        .adrs1          (adrs1),
        .adrs2          (adrs2),
        .adrs_out       (adrs_out),
        .wr_data1       (pixel_in),
        .wr_data2       (pair_max),
        .rd_data_out    (rd_data_out),
        .pair_slot_data (pair_slot_data)
    );

    pool_max_datapath u_datapath
    (
        .clk            (clk),
        .nrst           (nrst),
        .pixel_in       (pixel_in),
        .buffer_data    (rd_data_out),
        .pair_slot_data (pair_slot_data),
        .mux_en         (mux_en),
        .pair_max       (pair_max),
        .pool_out       (pool_out)
    );

endmodule

/* dv/pool_tb.sv */
`timescale 1ns/1ps

module pool_tb;

    localparam int frame_pixels     = pool_pkg::frame_width * pool_pkg::frame_width;
    localparam int blocks_per_frame = pool_pkg::pool_width * pool_pkg::pool_width;
    localparam int frame_words      = frame_pixels + blocks_per_frame;  // pixels, then results
    localparam int file_frames      = 2;
    localparam int reset_cycles     = 5;
    localparam int max_gap          = 5;
    localparam int idle_checks      = 4;
    localparam int frames_driven    = 4;
    localparam int frames_completed = 3;
    localparam int stray_pixel      = 20;   // start pulsed again in the middle of a frame
    localparam int abort_pixel      = 36;   // reset lands inside an even row
    localparam int timeout_cycles   = frames_driven * (frame_pixels + max_gap)
                                    + 2 * reset_cycles + idle_checks + 100;

    logic             clk = 1'b0;
    logic             nrst;
    logic             start;
    pool_pkg::pixel_t pixel_in;
    pool_pkg::pixel_t pool_out;
    logic             pool_valid;
    logic             pooling_finish;

    pool_pkg::pixel_t data_mem [file_frames * frame_words];

    // one entry per pooled result still in flight
    pool_pkg::pixel_t exp_value_q [$];
    int               exp_due_q   [$];
    logic             exp_last_q  [$];

    int cycle_count;
    int value_errors;
    int strobe_errors;
    int other_errors;
    int pushed_count;
    int result_count;
    int finish_count;

    pool_top u_pool_top
    (
        .clk            (clk),
        .nrst           (nrst),
        .start          (start),
        .pixel_in       (pixel_in),
        .pool_out       (pool_out),
        .pool_valid     (pool_valid),
        .pooling_finish (pooling_finish)
    );

    always #5 clk = ~clk;

    always @(posedge clk)
    begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= timeout_cycles)
        begin
            $display("timeout: the run is still busy after %0d cycles", cycle_count);
            print_summary();
            $display("sim failed");
            $finish;
        end
    end

    // signed maximum of one 2x2 block taken straight from the pixels in the file
    function automatic pool_pkg::pixel_t max_of_block(input int frame_sel, input int block_row,
                                                      input int block_col);
        pool_pkg::pixel_t best;
        pool_pkg::pixel_t candidate;
        int               base;
        base = frame_sel * frame_words + 2 * block_row * pool_pkg::frame_width + 2 * block_col;
        best = data_mem[base];
        for (int dr = 0; dr < 2; dr++)
        begin
            for (int dc = 0; dc < 2; dc++)
            begin
                candidate = data_mem[base + dr * pool_pkg::frame_width + dc];
                if (candidate > best)
                begin
                    best = candidate;
                end
            end
        end
        return best;
    endfunction

    task automatic check_file();
        pool_pkg::pixel_t computed;
        pool_pkg::pixel_t stored;
        if ($isunknown(data_mem[file_frames * frame_words - 1]))
        begin
            $display("the data file dv/pool_input.txt is missing or too short");
            other_errors++;
        end
        for (int f = 0; f < file_frames; f++)
        begin
            for (int br = 0; br < pool_pkg::pool_width; br++)
            begin
                for (int bc = 0; bc < pool_pkg::pool_width; bc++)
                begin
                    computed = max_of_block(f, br, bc);
                    stored   = data_mem[f * frame_words + frame_pixels
                                        + br * pool_pkg::pool_width + bc];
                    if (computed !== stored)
                    begin
                        $display("data file frame %0d block (%0d,%0d) holds %0d, pixels give %0d",
                                 f, br, bc, stored, computed);
                        other_errors++;
                    end
                end
            end
        end
    endtask

    task automatic print_summary();
        $display("errors: %0d value, %0d strobe, %0d other; %0d results, %0d frames finished",
                 value_errors, strobe_errors, other_errors, result_count, finish_count);
    endtask

    task automatic apply_reset();
        nrst  = 1'b0;
        start = 1'b0;
        exp_value_q.delete();   // anything in flight is lost with the reset
        exp_due_q.delete();
        exp_last_q.delete();
        repeat (reset_cycles) @(negedge clk);
        nrst = 1'b1;
    endtask

    task automatic idle_cycles(input int count);
        repeat (count)
        begin
            @(negedge clk);
            start    = 1'b0;
            pixel_in = pool_pkg::pixel_t'($urandom);   // ignored while idle
        end
    endtask

    // stray_at and abort_at are pixel indices, -1 leaves them out
    task automatic drive_frame(input int frame_sel, input int gap_cycles, input int stray_at,
                               input int abort_at);
        int               base;
        pool_pkg::count_t row;
        pool_pkg::count_t col;
        int               block;
        base = frame_sel * frame_words;
        idle_cycles(gap_cycles);
        for (int idx = 0; idx < frame_pixels; idx++)
        begin
            @(negedge clk);
            if (idx == abort_at)
            begin
                apply_reset();
                return;
            end
            row      = pool_pkg::count_t'(idx / pool_pkg::frame_width);
            col      = pool_pkg::count_t'(idx % pool_pkg::frame_width);
            start    = (idx == 0) || (idx == stray_at);
            pixel_in = data_mem[base + idx];
            if ((row % 2 == 1) && (col % 2 == 1))
            begin
                // this pixel closes a block, the result is due one clock later
                block = (row / 2) * pool_pkg::pool_width + col / 2;
                exp_value_q.push_back(data_mem[base + frame_pixels + block]);
                exp_due_q.push_back(cycle_count + 1);
                exp_last_q.push_back(idx == frame_pixels - 1);
                pushed_count++;
            end
        end
    endtask

    task automatic check_result();
        pool_pkg::pixel_t expected;
        logic             last;
        expected = exp_value_q.pop_front();
        last     = exp_last_q.pop_front();
        void'(exp_due_q.pop_front());
        if (pool_valid !== 1'b1)
        begin
            $display("Error: time %0t, pool_valid, expected 1, got %b", $time, pool_valid);
            strobe_errors++;
        end
        else
        begin
            result_count++;
            if (pool_out !== expected)
            begin
                $display("Error: time %0t, pool_out, expected %0d, got %0d",
                         $time, expected, pool_out);
                value_errors++;
            end
        end
        if (pooling_finish !== last)
        begin
            $display("Error: time %0t, pooling_finish, expected %b, got %b",
                     $time, last, pooling_finish);
            strobe_errors++;
        end
        if (pooling_finish && pool_valid)
        begin
            finish_count++;
        end
    endtask

    // outputs are registered, so they are settled at the falling edge
    always @(negedge clk)
    begin
        if (!nrst)
        begin
            if (pool_valid !== 1'b0)
            begin
                $display("Error: time %0t, pool_valid, expected 0, got %b", $time, pool_valid);
                strobe_errors++;
            end
            if (pooling_finish !== 1'b0)
            begin
                $display("Error: time %0t, pooling_finish, expected 0, got %b",
                         $time, pooling_finish);
                strobe_errors++;
            end
        end
        else if ((exp_due_q.size() != 0) && (exp_due_q[0] == cycle_count))
        begin
            check_result();
        end
        else
        begin
            if (pool_valid !== 1'b0)
            begin
                $display("Error: time %0t, pool_valid, expected 0, got %b", $time, pool_valid);
                strobe_errors++;
            end
            if (pooling_finish !== 1'b0)
            begin
                $display("Error: time %0t, pooling_finish, expected 0, got %b",
                         $time, pooling_finish);
                strobe_errors++;
            end
        end
    end

    initial
    begin
        cycle_count   = 0;
        value_errors  = 0;
        strobe_errors = 0;
        other_errors  = 0;
        pushed_count  = 0;
        result_count  = 0;
        finish_count  = 0;
        nrst          = 1'b0;
        start         = 1'b0;
        pixel_in      = '0;
        void'($urandom(35));
        $readmemh("dv/pool_input.txt", data_mem);
        check_file();

        apply_reset();
        idle_cycles(idle_checks);                        // no output without a start
        drive_frame(0, $urandom % (max_gap + 1), stray_pixel, -1);
        drive_frame(1, 0, -1, -1);                       // starts right after the last pixel
        drive_frame(0, $urandom % (max_gap + 1), -1, abort_pixel);
        drive_frame(1, $urandom % (max_gap + 1), -1, -1);

        idle_cycles(1);
        while (exp_due_q.size() != 0)
        begin
            idle_cycles(1);
        end
        idle_cycles(idle_checks);

        if (result_count != pushed_count)
        begin
            $display("only %0d of %0d pooled results arrived", result_count, pushed_count);
            other_errors++;
        end
        if (finish_count != frames_completed)
        begin
            $display("pooling_finish pulsed %0d times for %0d finished frames",
                     finish_count, frames_completed);
            other_errors++;
        end
        print_summary();
        if (value_errors + strobe_errors + other_errors == 0)
        begin
            $display("sim passed");
        end
        else
        begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

/* dv/pool_input.txt */
// per frame: 64 signed 16-bit pixels in raster order, then 16 pooled maxima in block order
// two frames, four hex words per line
0003 0007 fffe 0005
000a 000a fff8 ffff
0001 0004 0006 fffd
000a 0002 fffb fff7
ffec fff1 0064 0063
0000 0000 7fff 8000
ffe2 fff4 0062 0065
0000 ffff 0005 0006
000c 000c 000c 000c
fffc fffc fffc fffc
000c 000c 000c 000c
fffc fffc fffc fffc
0100 ff00 03e8 07d0
ff9c ff38 0007 0008
00ff 012c 05dc 07cf
fed4 ffce 0009 0006
0007 0006 000a ffff
fff4 0065 0000 7fff
000c 000c fffc fffc
012c 07d0 ffce 0009
ffff fffe fffd fffc
fffb fffa fff9 fff8
fff7 fff6 fff5 fff4
fff3 fff2 fff1 fff0
ff9c ff38 fed4 ffce
8000 8000 fc18 fc19
ff6a ff9b ffd8 fe70
8000 8001 fc1a fc17
0032 ffce 0000 ffff
0014 001e 0028 000a
ffc4 0031 fffe fffd
001f 0013 0027 0029
fff9 fff9 fff9 fff9
0001 0002 0003 0004
fff9 fff9 fff9 fff9
0008 0007 0006 0005
ffff fffd fffb fff9
ff9c ffd8 8001 fc1a
0032 0000 001f 0029
fff9 fff9 0008 0006

/* compile.f */
design/pool_pkg.sv
design/pool_control.sv
design/pool_line_buffer.sv
design/pool_max_datapath.sv
design/pool_top.sv
dv/pool_tb.sv
